// File: rtl/uart_periph_pkg.sv
`default_nettype none

package uart_periph_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame format and sizes
    ////////////////////////////////////////////////////////////////////////////

    // data bits per frame
    localparam int unsigned DW = 8;
    // stop bits
    localparam int unsigned SW = 1;
    // full shift sequence of start, data and stop bits
    localparam int unsigned SL = 1 + DW + SW;
    // serializer bit counter width
    localparam int unsigned CW = $clog2(SL);
    // deserializer data bit counter width
    localparam int unsigned BW = $clog2(DW);

    // baud divisor width, one bit lasts divisor plus one clocks
    localparam int unsigned RW = 16;
    localparam logic [RW-1:0] BDR_RST = RW'(15);

    // fifo depths
    localparam int unsigned TX_DEPTH = 8;
    localparam int unsigned RX_DEPTH = 4;

    ////////////////////////////////////////////////////////////////////////////
    // host bus
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned AW = 2;

    // register map
    typedef enum logic [AW-1:0] {
        adr_baud   = 2'd0,
        adr_status = 2'd1,
        adr_txdata = 2'd2,
        adr_rxdata = 2'd3
    } bus_adr_e;

    // op_none means no request this cycle
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2
    } bus_op_e;

    typedef struct packed {
        bus_op_e     op;
        bus_adr_e    adr;
        logic [31:0] wdt;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdt;
        logic        err;
    } bus_rsp_t;

    // status word, frame_err sits in bit 0
    typedef struct packed {
        logic tx_full;
        logic tx_empty;
        logic rx_empty;
        logic rx_overrun;
        logic frame_err;
    } status_t;

    ////////////////////////////////////////////////////////////////////////////
    // receive path
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        des_idle,
        des_start,
        des_data,
        des_stop
    } des_state_e;

    typedef struct packed {
        logic [DW-1:0] dat;
        logic          frame_err;
    } rx_byte_t;

endpackage: uart_periph_pkg

`default_nettype wire

// File: rtl/uart_fifo.sv
`default_nettype none

module uart_fifo import uart_periph_pkg::*; #(
    parameter int unsigned DEPTH = 4
)(
    input  wire logic          clk,
    input  wire logic          rst,
    // write side
    input  wire logic          push,
    input  wire logic [DW-1:0] wdt,
    output logic               full,
    // read side
    input  wire logic          pop,
    output logic [DW-1:0]      rdt,
    output logic               vld,
    output logic               empty
);

    logic [DW-1:0]              mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    // occupancy
    logic [$clog2(DEPTH+1)-1:0] cnt;
    logic                       push_ok;
    logic                       pop_ok;

    // pushes when full and pops when empty are dropped
    assign push_ok = push & ~full;
    assign pop_ok  = pop & ~empty;

    // storage
    always_ff @(posedge clk) begin
        if (push_ok) mem[wr_ptr] <= wdt;
    end

    // pointers wrap at DEPTH
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    // flags follow the registered count
    assign full  = (cnt == ($clog2(DEPTH+1))'(DEPTH));
    assign empty = (cnt == '0);
    assign vld   = ~empty;

    // head of queue, valid while vld
    assign rdt = mem[rd_ptr];

    a_no_overflow:  assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule: uart_fifo

`default_nettype wire

// File: rtl/uart_ser.sv
`default_nettype none

module uart_ser import uart_periph_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    // baud divisor
    input  wire logic [RW-1:0] cfg_bdr,
    // byte stream from tx fifo
    input  wire logic          str_vld,
    input  wire logic [DW-1:0] str_dat,
    output logic               str_rdy,
    // serial line
    output logic               txd
);

    // stream handshake
    logic          str_trn;

    // baud timing
    logic [RW-1:0] bdr_cnt;
    logic          bdr_end;

    // position within the frame
    logic [CW-1:0] shf_cnt;
    logic          shf_end;
    logic          shf_run;

    // byte plus start bit
    logic [DW:0]   shf_dat;

    ////////////////////////////////////////////////////////////////////////////
    // stream side
    ////////////////////////////////////////////////////////////////////////////

    assign str_trn = str_vld & str_rdy;

    // accept when idle or right as the last stop bit ends
    assign str_rdy = ~shf_run | (shf_end & bdr_end);

    ////////////////////////////////////////////////////////////////////////////
    // bit timing
    ////////////////////////////////////////////////////////////////////////////

    assign bdr_end = (bdr_cnt == cfg_bdr);
    assign shf_end = (shf_cnt == CW'(SL - 1));

    // baud counter restarts on each transfer
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bdr_cnt <= '0;
        end else if (str_trn) begin
            bdr_cnt <= '0;
        end else if (shf_run) begin
            bdr_cnt <= bdr_end ? '0 : bdr_cnt + 1'b1;
        end
    end

    // bit counter and run flag
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            shf_cnt <= '0;
            shf_run <= 1'b0;
        end else if (str_trn) begin
            shf_cnt <= '0;
            shf_run <= 1'b1;
        end else if (shf_run && bdr_end) begin
            if (shf_end) begin
                shf_cnt <= '0;
                shf_run <= 1'b0;
            end else begin
                shf_cnt <= shf_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shifter
    ////////////////////////////////////////////////////////////////////////////

    // line idles high, so reset to ones
    // ones shift in behind the data and form the stop bits
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            shf_dat <= '1;
        end else if (str_trn) begin
            shf_dat <= {str_dat, 1'b0};
        end else if (shf_run && bdr_end) begin
            shf_dat <= {1'b1, shf_dat[DW:1]};
        end
    end

    assign txd = shf_dat[0];

    // no stray start bits between frames
    a_idle_high: assert property (@(posedge clk) disable iff (rst) !shf_run |-> txd);

endmodule: uart_ser

`default_nettype wire

// File: rtl/uart_des.sv
`default_nettype none

module uart_des import uart_periph_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    // baud divisor
    input  wire logic [RW-1:0] cfg_bdr,
    // serial line
    input  wire logic          rxd,
    // received byte strobe
    output logic               rx_vld,
    output rx_byte_t           rx_byte
);

    // synchronizer and edge detect
    logic [1:0]    rxd_sync;
    logic          rxd_dly;
    logic          rxd_bit;
    logic          rxd_fall;

    des_state_e    state;

    // baud timing
    logic [RW-1:0] bdr_cnt;
    logic          bdr_end;
    logic          bdr_hlf;

    // data bit index
    logic [BW-1:0] bit_cnt;

    // stop bit sampled, waiting out its second half
    logic          stp_smp;
    logic          stp_bit;

    logic [DW-1:0] shf_dat;

    ////////////////////////////////////////////////////////////////////////////
    // line input
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rxd_sync <= '1;
            rxd_dly  <= 1'b1;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rxd_dly  <= rxd_sync[1];
        end
    end

    assign rxd_bit  = rxd_sync[1];
    assign rxd_fall = rxd_dly & ~rxd_bit;

    // full period and mid-bit points
    assign bdr_end = (bdr_cnt == cfg_bdr);
    assign bdr_hlf = (bdr_cnt == (cfg_bdr >> 1));

    ////////////////////////////////////////////////////////////////////////////
    // receive FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= des_idle;
            bdr_cnt <= '0;
            bit_cnt <= '0;
            stp_smp <= 1'b0;
            rx_vld  <= 1'b0;
        end else begin
            rx_vld <= 1'b0;
            case (state)
                des_idle: begin
                    bdr_cnt <= '0;
                    if (rxd_fall) state <= des_start;
                end
                // recheck start at mid-bit, high there means a glitch
                des_start: begin
                    if (bdr_hlf) begin
                        bdr_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_bit ? des_idle : des_data;
                    end else begin
                        bdr_cnt <= bdr_cnt + 1'b1;
                    end
                end
                // one sample per period, lsb first
                des_data: begin
                    if (bdr_end) begin
                        bdr_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BW'(DW - 1)) state <= des_stop;
                    end else begin
                        bdr_cnt <= bdr_cnt + 1'b1;
                    end
                end
                des_stop: begin
                    if (!stp_smp) begin
                        if (bdr_end) begin
                            bdr_cnt <= '0;
                            stp_smp <= 1'b1;
                        end else begin
                            bdr_cnt <= bdr_cnt + 1'b1;
                        end
                    end else if (bdr_hlf || rxd_fall) begin
                        // a start edge here cuts the wait short for back-to-back frames
                        bdr_cnt <= '0;
                        stp_smp <= 1'b0;
                        rx_vld  <= 1'b1;
                        state   <= rxd_fall ? des_start : des_idle;
                    end else begin
                        bdr_cnt <= bdr_cnt + 1'b1;
                    end
                end
                default: state <= des_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == des_data && bdr_end) shf_dat <= {rxd_bit, shf_dat[DW-1:1]};
        if (state == des_stop && !stp_smp && bdr_end) stp_bit <= rxd_bit;
    end

    // held stable until the next frame's data phase
    assign rx_byte = '{dat: shf_dat, frame_err: ~stp_bit};

    a_vld_pulse: assert property (@(posedge clk) disable iff (rst) rx_vld |=> !rx_vld);

endmodule: uart_des

`default_nettype wire

// File: rtl/uart_regs.sv
`default_nettype none

module uart_regs import uart_periph_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    // host bus
    input  wire bus_req_t      bus_req,
    output logic               rsp_vld,
    output bus_rsp_t           bus_rsp,
    // baud divisor
    output logic [RW-1:0]      cfg_bdr,
    // tx fifo write side
    output logic               tx_push,
    output logic [DW-1:0]      tx_wdt,
    input  wire logic          tx_full,
    input  wire logic          tx_empty,
    // rx fifo read side
    output logic               rx_pop,
    input  wire logic [DW-1:0] rx_rdt,
    input  wire logic          rx_empty,
    // deserializer strobe
    input  wire logic          rx_vld,
    input  wire rx_byte_t      rx_byte,
    input  wire logic          rx_full
);

    logic     req_vld;
    logic     bdr_wen;
    logic     sts_wen;
    status_t  sts;
    status_t  sts_clr;
    bus_rsp_t rsp_nxt;

    // sticky flags
    logic     rx_overrun;
    logic     frame_err;
    logic     ovr_set;
    logic     fer_set;

    assign req_vld = (bus_req.op != op_none);

    assign sts = '{
        tx_full:    tx_full,
        tx_empty:   tx_empty,
        rx_empty:   rx_empty,
        rx_overrun: rx_overrun,
        frame_err:  frame_err
    };

    // write one to clear
    assign sts_clr = status_t'(bus_req.wdt[$bits(status_t)-1:0]);

    // tx data is the low byte of the write
    assign tx_wdt = bus_req.wdt[DW-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // request decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rsp_nxt = '0;
        bdr_wen = 1'b0;
        sts_wen = 1'b0;
        tx_push = 1'b0;
        rx_pop  = 1'b0;
        case (bus_req.op)
            op_read: begin
                case (bus_req.adr)
                    adr_baud:   rsp_nxt.rdt = 32'(cfg_bdr);
                    adr_status: rsp_nxt.rdt = 32'(sts);
                    // empty read answers err with zero data
                    adr_rxdata: begin
                        rx_pop      = ~rx_empty;
                        rsp_nxt.rdt = rx_empty ? '0 : 32'(rx_rdt);
                        rsp_nxt.err = rx_empty;
                    end
                    default:    rsp_nxt.err = 1'b1;
                endcase
            end
            op_write: begin
                case (bus_req.adr)
                    adr_baud:   bdr_wen = 1'b1;
                    adr_status: sts_wen = 1'b1;
                    // full fifo drops the byte
                    adr_txdata: begin
                        tx_push     = ~tx_full;
                        rsp_nxt.err = tx_full;
                    end
                    default:    rsp_nxt.err = 1'b1;
                endcase
            end
            op_none: rsp_nxt = '0;
            default: rsp_nxt.err = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg_bdr <= BDR_RST;
        end else if (bdr_wen) begin
            cfg_bdr <= bus_req.wdt[RW-1:0];
        end
    end

    // a good byte with no room is an overrun
    assign ovr_set = rx_vld & ~rx_byte.frame_err & rx_full;
    assign fer_set = rx_vld & rx_byte.frame_err;

    // a new event wins over a clear in the same cycle
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            if (ovr_set) begin
                rx_overrun <= 1'b1;
            end else if (sts_wen && sts_clr.rx_overrun) begin
                rx_overrun <= 1'b0;
            end
            if (fer_set) begin
                frame_err <= 1'b1;
            end else if (sts_wen && sts_clr.frame_err) begin
                frame_err <= 1'b0;
            end
        end
    end

    // response one cycle after the request
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= req_vld;
        end
    end

    always_ff @(posedge clk) begin
        bus_rsp <= rsp_nxt;
    end

    // an idle cycle carries an all-zero response
    a_rsp_only_on_req: assert property (@(posedge clk) disable iff (rst)
        !rsp_vld |-> (bus_rsp == '0));

endmodule: uart_regs

`default_nettype wire

// File: rtl/uart_periph_top.sv
`default_nettype none

module uart_periph_top import uart_periph_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    // host bus
    input  wire bus_req_t bus_req,
    output logic          rsp_vld,
    output bus_rsp_t      bus_rsp,
    // serial lines
    output logic          txd,
    input  wire logic     rxd
);

    logic [RW-1:0] cfg_bdr;

    // transmit path
    logic          tx_push;
    logic [DW-1:0] tx_wdt;
    logic          tx_full;
    logic          tx_empty;
    logic          tx_vld;
    logic [DW-1:0] tx_dat;
    logic          tx_rdy;
    logic          tx_pop;

    // receive path
    logic          rx_vld;
    rx_byte_t      rx_byte;
    logic          rx_push;
    logic          rx_full;
    logic          rx_pop;
    logic [DW-1:0] rx_rdt;
    logic          rx_empty;

    ////////////////////////////////////////////////////////////////////////////
    // register block
    ////////////////////////////////////////////////////////////////////////////

    uart_regs i_uart_regs (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (bus_req),
        .rsp_vld  (rsp_vld),
        .bus_rsp  (bus_rsp),
        .cfg_bdr  (cfg_bdr),
        .tx_push  (tx_push),
        .tx_wdt   (tx_wdt),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .rx_pop   (rx_pop),
        .rx_rdt   (rx_rdt),
        .rx_empty (rx_empty),
        .rx_vld   (rx_vld),
        .rx_byte  (rx_byte),
        .rx_full  (rx_full)
    );

    ////////////////////////////////////////////////////////////////////////////
    // transmit
    ////////////////////////////////////////////////////////////////////////////

    // valid/ready transfer pops the fifo
    assign tx_pop = tx_vld & tx_rdy;

    uart_fifo #(.DEPTH(TX_DEPTH)) tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (tx_push),
        .wdt   (tx_wdt),
        .full  (tx_full),
        .pop   (tx_pop),
        .rdt   (tx_dat),
        .vld   (tx_vld),
        .empty (tx_empty)
    );

    uart_ser i_uart_ser (
        .clk     (clk),
        .rst     (rst),
        .cfg_bdr (cfg_bdr),
        .str_vld (tx_vld),
        .str_dat (tx_dat),
        .str_rdy (tx_rdy),
        .txd     (txd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // receive
    ////////////////////////////////////////////////////////////////////////////

    uart_des i_uart_des (
        .clk     (clk),
        .rst     (rst),
        .cfg_bdr (cfg_bdr),
        .rxd     (rxd),
        .rx_vld  (rx_vld),
        .rx_byte (rx_byte)
    );

    // only good frames with room are stored
    assign rx_push = rx_vld & ~rx_byte.frame_err & ~rx_full;

    uart_fifo #(.DEPTH(RX_DEPTH)) rx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rx_push),
        .wdt   (rx_byte.dat),
        .full  (rx_full),
        .pop   (rx_pop),
        .rdt   (rx_rdt),
        .vld   (),
        .empty (rx_empty)
    );

endmodule: uart_periph_top

`default_nettype wire

// File: dv/uart_tb_clk.sv
`default_nettype none

// free running testbench clock
module uart_tb_clk (
    output logic clk
);

    // half of the 10 unit period
    localparam int unsigned HALF = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF clk = ~clk;
        end
    end

endmodule: uart_tb_clk

`default_nettype wire

// File: dv/uart_tb.sv
`default_nettype none

module uart_tb import uart_periph_pkg::*; ();

    localparam int unsigned SEED      = 10926;
    localparam logic [RW-1:0] TEST_BDR = RW'(3);
    // clocks per bit and per frame at the test divisor
    localparam int unsigned BIT_CYC   = 32'(TEST_BDR) + 1;
    localparam int unsigned FRM_CYC   = SL * BIT_CYC;
    // loopback, burst, overrun, overrun wait, framing
    localparam int unsigned N_FRAMES  = 1 + TX_DEPTH + (RX_DEPTH + 2) + 2 + 2;
    localparam int unsigned CYC_LIMIT = N_FRAMES * FRM_CYC + 2000;

    logic        clk;
    logic        rst;
    bus_req_t    bus_req;
    logic        rsp_vld;
    bus_rsp_t    bus_rsp;
    logic        txd;
    logic        rxd;
    // rxd source select and the directly driven line
    logic        loop_en;
    logic        drv_line;
    int unsigned cyc = 0;

    ////////////////////////////////////////////////////////////////////////////
    // clock, DUT and line mux
    ////////////////////////////////////////////////////////////////////////////

    uart_tb_clk i_uart_tb_clk (
        .clk (clk)
    );

    uart_periph_top i_uart_periph_top (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .rsp_vld (rsp_vld),
        .bus_rsp (bus_rsp),
        .txd     (txd),
        .rxd     (rxd)
    );

    assign rxd = loop_en ? txd : drv_line;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    function automatic bus_rsp_t make_rsp(input logic [31:0] rdt, input logic err);
        return '{rdt: rdt, err: err};
    endfunction

    function automatic status_t make_status(input logic tx_full, input logic tx_empty,
                                            input logic rx_empty, input logic rx_overrun,
                                            input logic frame_err);
        return '{tx_full: tx_full, tx_empty: tx_empty, rx_empty: rx_empty,
                 rx_overrun: rx_overrun, frame_err: frame_err};
    endfunction

    task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s, rdt %h err %b, expected rdt %h err %b",
                $time, what, got.rdt, got.err, exp.rdt, exp.err));
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s, status %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    // one request, response sampled mid-cycle after the next edge
    task automatic bus_access(input bus_op_e op, input bus_adr_e adr, input logic [31:0] wdt,
                              output bus_rsp_t rsp);
        @(posedge clk);
        bus_req <= '{op: op, adr: adr, wdt: wdt};
        @(posedge clk);
        bus_req <= '{op: op_none, adr: adr_baud, wdt: 32'd0};
        @(negedge clk);
        if (!rsp_vld) begin
            stop_on_error($sformatf("no bus response one cycle after the request at %0t", $time));
        end
        rsp = bus_rsp;
    endtask

    task automatic bus_write(input bus_adr_e adr, input logic [31:0] wdt, output bus_rsp_t rsp);
        bus_access(op_write, adr, wdt, rsp);
    endtask

    task automatic bus_read(input bus_adr_e adr, output bus_rsp_t rsp);
        bus_access(op_read, adr, 32'd0, rsp);
    endtask

    // padding above the flags must read zero
    task automatic read_status(output status_t sts);
        bus_rsp_t rsp;
        bus_read(adr_status, rsp);
        check_rsp(rsp, make_rsp(32'(rsp.rdt[$bits(status_t)-1:0]), 1'b0), "status read");
        sts = status_t'(rsp.rdt[$bits(status_t)-1:0]);
    endtask

    task automatic expect_status(input status_t exp, input string what);
        status_t sts;
        read_status(sts);
        check_status(sts, exp, what);
    endtask

    task automatic wait_rx_ready();
        status_t sts;
        read_status(sts);
        while (sts.rx_empty) read_status(sts);
    endtask

    task automatic wait_tx_empty();
        status_t sts;
        read_status(sts);
        while (!sts.tx_empty) read_status(sts);
    endtask

    // start, lsb first data, one stop bit of the given level
    task automatic send_raw_frame(input logic [DW-1:0] dat, input logic stp);
        logic [SL-1:0] bits;
        bits = {stp, dat, 1'b0};
        for (int i = 0; i < SL; i++) begin
            @(posedge clk);
            drv_line <= bits[i];
            repeat (BIT_CYC - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_line <= 1'b1;
        // idle gap, receiver finishes the stop bit
        repeat (2 * BIT_CYC) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        bus_rsp_t rsp;
        bus_read(adr_baud, rsp);
        check_rsp(rsp, make_rsp(32'(BDR_RST), 1'b0), "baud after reset");
        expect_status(make_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), "status after reset");
        if (txd !== 1'b1) begin
            stop_on_error($sformatf("mismatch at %0t: txd not idle high after reset", $time));
        end
    endtask

    task automatic test_loopback_byte();
        bus_rsp_t      rsp;
        logic [DW-1:0] dat;
        dat = DW'($urandom());
        bus_write(adr_baud, 32'(TEST_BDR), rsp);
        check_rsp(rsp, make_rsp(32'd0, 1'b0), "baud write");
        bus_read(adr_baud, rsp);
        check_rsp(rsp, make_rsp(32'(TEST_BDR), 1'b0), "baud readback");
        bus_write(adr_txdata, 32'(dat), rsp);
        check_rsp(rsp, make_rsp(32'd0, 1'b0), "tx push");
        wait_rx_ready();
        bus_read(adr_rxdata, rsp);
        check_rsp(rsp, make_rsp(32'(dat), 1'b0), "loopback byte");
        // second pop finds the fifo empty
        bus_read(adr_rxdata, rsp);
        check_rsp(rsp, make_rsp(32'd0, 1'b1), "read of empty rx fifo");
    endtask

    task automatic test_ordering();
        bus_rsp_t      rsp;
        logic [DW-1:0] sent [$];
        logic [DW-1:0] dat;
        for (int i = 0; i < TX_DEPTH; i++) begin
            dat = DW'($urandom());
            sent.push_back(dat);
            bus_write(adr_txdata, 32'(dat), rsp);
            check_rsp(rsp, make_rsp(32'd0, 1'b0), "tx push in burst");
        end
        // rx fifo is shallower, so drain as bytes land
        for (int i = 0; i < TX_DEPTH; i++) begin
            wait_rx_ready();
            bus_read(adr_rxdata, rsp);
            check_rsp(rsp, make_rsp(32'(sent[i]), 1'b0), "burst byte order");
        end
    endtask

    task automatic test_overrun();
        bus_rsp_t      rsp;
        status_t       clr;
        logic [DW-1:0] sent [$];
        logic [DW-1:0] dat;
        for (int i = 0; i < RX_DEPTH + 2; i++) begin
            dat = DW'($urandom());
            sent.push_back(dat);
            bus_write(adr_txdata, 32'(dat), rsp);
            check_rsp(rsp, make_rsp(32'd0, 1'b0), "tx push for overrun");
        end
        wait_tx_empty();
        // last frames still on the line
        repeat (2 * FRM_CYC) @(posedge clk);
        expect_status(make_status(1'b0, 1'b1, 1'b0, 1'b1, 1'b0), "status after overrun");
        for (int i = 0; i < RX_DEPTH; i++) begin
            bus_read(adr_rxdata, rsp);
            check_rsp(rsp, make_rsp(32'(sent[i]), 1'b0), "byte kept before overrun");
        end
        bus_read(adr_rxdata, rsp);
        check_rsp(rsp, make_rsp(32'd0, 1'b1), "read past kept bytes");
        clr = '0;
        clr.rx_overrun = 1'b1;
        bus_write(adr_status, 32'(clr), rsp);
        check_rsp(rsp, make_rsp(32'd0, 1'b0), "overrun clear write");
        expect_status(make_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), "status after overrun clear");
    endtask

    task automatic test_framing();
        bus_rsp_t      rsp;
        status_t       clr;
        logic [DW-1:0] dat;
        @(posedge clk);
        drv_line <= 1'b1;
        loop_en  <= 1'b0;
        // stop bit held low
        send_raw_frame(DW'($urandom()), 1'b0);
        expect_status(make_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b1), "status after bad stop bit");
        dat = DW'($urandom());
        send_raw_frame(dat, 1'b1);
        wait_rx_ready();
        bus_read(adr_rxdata, rsp);
        check_rsp(rsp, make_rsp(32'(dat), 1'b0), "good frame after bad one");
        // flag is sticky until cleared
        expect_status(make_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b1), "frame error still set");
        clr = '0;
        clr.frame_err = 1'b1;
        bus_write(adr_status, 32'(clr), rsp);
        check_rsp(rsp, make_rsp(32'd0, 1'b0), "frame error clear write");
        expect_status(make_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), "status after frame clear");
    endtask

    task automatic test_illegal_access();
        bus_rsp_t rsp;
        bus_read(adr_txdata, rsp);
        check_rsp(rsp, make_rsp(32'd0, 1'b1), "read of txdata");
        bus_write(adr_rxdata, 32'h0000_00a5, rsp);
        check_rsp(rsp, make_rsp(32'd0, 1'b1), "write of rxdata");
        bus_read(adr_baud, rsp);
        check_rsp(rsp, make_rsp(32'(TEST_BDR), 1'b0), "baud after illegal access");
        expect_status(make_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), "status after illegal access");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        rst      <= 1'b1;
        bus_req  <= '{op: op_none, adr: adr_baud, wdt: 32'd0};
        loop_en  <= 1'b1;
        drv_line <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_loopback_byte();
        test_ordering();
        test_overrun();
        test_framing();
        test_illegal_access();
        // any failed check has already stopped the run
        $display("*** TEST PASSED ***");
        $finish;
    end

    // bound from the frame count of all tests
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            stop_on_error($sformatf("timeout, tests still running after %0d cycles", cyc));
        end
    end

endmodule: uart_tb

`default_nettype wire

// File: uart_periph.f
rtl/uart_periph_pkg.sv
rtl/uart_fifo.sv
rtl/uart_ser.sv
rtl/uart_des.sv
rtl/uart_regs.sv
rtl/uart_periph_top.sv
dv/uart_tb_clk.sv
dv/uart_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module uart_tb -f uart_periph.f -o uart_tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/uart_tb_sim > sim.log 2>&1
grep -qF '*** TEST PASSED ***' sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
